// ==== isa_pkg.sv ====
// Instruction encoding shared by the retire stage: decoded instruction fields and fault codes
`default_nettype none

package isa_pkg;

	typedef logic [4:0] register_idx_t;

	// Writing this register redirects the thread
	localparam register_idx_t REG_PC = 5'd31;

	typedef enum logic [2:0]
	{
		MEM_B = 3'd0,
		MEM_BX,
		MEM_S,
		MEM_SX,
		MEM_L,
		MEM_BLOCK,
		MEM_GATHER
	} memory_op_t;

	typedef enum logic [1:0]
	{
		BRANCH_CALL_OFFSET = 2'd0,
		BRANCH_CALL_REGISTER,
		BRANCH_OTHER
	} branch_type_t;

	// Which pipeline a rollback came from
	typedef enum logic
	{
		PIPE_ARITH = 1'b0,
		PIPE_MEM = 1'b1
	} pipeline_sel_t;

	typedef enum logic [2:0]
	{
		FR_NONE = 3'd0,
		FR_ILLEGAL_INSTRUCTION,
		FR_IFETCH_FAULT,
		FR_ITLB_MISS,
		FR_DTLB_MISS,
		FR_INVALID_ACCESS
	} fault_reason_t;

	typedef struct packed
	{
		logic [31:0] pc;
		logic illegal;
		logic ifetch_fault;
		logic tlb_miss;
		logic has_dest;
		register_idx_t dest_reg;
		logic dest_is_vector;
		logic is_compare;
		logic is_branch;
		branch_type_t branch_type;
		logic is_load;
		logic is_cache_control;
		memory_op_t memory_access_type;
	} decoded_instruction_t;

endpackage

`default_nettype wire

// ==== core_config_pkg.sv ====
// Core geometry and the packed port bundles used between the retire stage blocks
`default_nettype none

package core_config_pkg;
	import isa_pkg::*;

	localparam int NUM_LANES = 4;
	localparam int NUM_THREADS = 4;
	localparam int LINE_BYTES = 16;

	typedef logic [31:0] scalar_t;
	// Lane 0 occupies the most significant word
	typedef scalar_t [0:NUM_LANES - 1] vector_t;
	typedef logic [NUM_LANES - 1:0] lane_mask_t;
	typedef logic [$clog2(NUM_THREADS) - 1:0] thread_idx_t;
	typedef logic [LINE_BYTES * 8 - 1:0] line_data_t;
	typedef logic [$clog2(NUM_LANES) - 1:0] lane_idx_t;

	typedef struct packed
	{
		logic valid;
		decoded_instruction_t instruction;
		thread_idx_t thread;
		vector_t result;
		lane_mask_t mask;
		logic rollback_en;
		scalar_t rollback_pc;
	} int_result_t;

	typedef struct packed
	{
		logic valid;
		decoded_instruction_t instruction;
		thread_idx_t thread;
		lane_mask_t lane_mask;
		logic [3:0] offset;
		lane_idx_t gather_lane;
		logic rollback_en;
		scalar_t rollback_pc;
		line_data_t load_data;
		logic access_fault;
		logic tlb_miss;
	} mem_result_t;

	typedef struct packed
	{
		logic [LINE_BYTES - 1:0] mask;
		line_data_t data;
	} store_bypass_t;

	typedef struct packed
	{
		vector_t value;
		lane_mask_t mask;
		scalar_t swapped_word;
	} aligned_load_t;

	typedef struct packed
	{
		logic en;
		thread_idx_t thread;
		scalar_t pc;
		pipeline_sel_t pipeline;
	} rollback_t;

	typedef struct packed
	{
		logic en;
		fault_reason_t reason;
		scalar_t pc;
		thread_idx_t thread;
		scalar_t access_addr;
	} fault_t;

	typedef struct packed
	{
		logic en;
		thread_idx_t thread;
		logic is_vector;
		vector_t value;
		lane_mask_t mask;
		register_idx_t reg_idx;
	} writeback_t;

endpackage

`default_nettype wire

// ==== load_aligner.sv ====
// Load formatter: applies store queue bypass bytes, then aligns and extends the loaded data
`default_nettype none
`timescale 1ns/1ps

module load_aligner
	import isa_pkg::*;
	import core_config_pkg::*;
(
	input wire mem_result_t mem_result,
	input wire store_bypass_t bypass,
	output aligned_load_t aligned_load
);

	line_data_t bypassed_line;
	line_data_t swapped_line;
	lane_idx_t word_idx;
	scalar_t load_word;
	scalar_t swapped_word;
	logic [7:0] byte_aligned;
	logic [15:0] half_aligned;
	lane_mask_t gather_oh;

	// Stores still sitting in the store queue override stale cache bytes
	always_comb
	begin
		for (int i = 0; i < LINE_BYTES; i++)
		begin
			if (bypass.mask[i])
				bypassed_line[i * 8 +: 8] = bypass.data[i * 8 +: 8];
			else
				bypassed_line[i * 8 +: 8] = mem_result.load_data[i * 8 +: 8];
		end
	end

	// Offset 0 is the top word of the line
	assign word_idx = ~mem_result.offset[3:2];
	assign load_word = bypassed_line[word_idx * 32 +: 32];
	assign swapped_word = {load_word[7:0], load_word[15:8], load_word[23:16], load_word[31:24]};

	always_comb
	begin
		case (mem_result.offset[1:0])
			2'd0: byte_aligned = load_word[31:24];
			2'd1: byte_aligned = load_word[23:16];
			2'd2: byte_aligned = load_word[15:8];
			default: byte_aligned = load_word[7:0];
		endcase

		if (mem_result.offset[1])
			half_aligned = {load_word[7:0], load_word[15:8]};
		else
			half_aligned = {load_word[23:16], load_word[31:24]};
	end

	// Byte reverse every word for block loads
	always_comb
	begin
		for (int w = 0; w < NUM_LANES; w++)
		begin
			swapped_line[w * 32 +: 32] = {bypassed_line[w * 32 +: 8],
				bypassed_line[w * 32 + 8 +: 8], bypassed_line[w * 32 + 16 +: 8],
				bypassed_line[w * 32 + 24 +: 8]};
		end
	end

	// Gather lane one-hot, lane 0 in the MSB
	always_comb
	begin
		for (int i = 0; i < NUM_LANES; i++)
			gather_oh[NUM_LANES - 1 - i] = mem_result.gather_lane == lane_idx_t'(i);
	end

	always_comb
	begin
		aligned_load.value = '0;
		aligned_load.mask = '1;
		aligned_load.swapped_word = swapped_word;
		case (mem_result.instruction.memory_access_type)
			MEM_B: aligned_load.value[0] = {24'b0, byte_aligned};
			MEM_BX: aligned_load.value[0] = {{24{byte_aligned[7]}}, byte_aligned};
			MEM_S: aligned_load.value[0] = {16'b0, half_aligned};
			MEM_SX: aligned_load.value[0] = {{16{half_aligned[15]}}, half_aligned};
			MEM_L: aligned_load.value[0] = swapped_word;
			MEM_BLOCK:
			begin
				aligned_load.value = vector_t'(swapped_line);
				aligned_load.mask = mem_result.lane_mask;
			end
			MEM_GATHER:
			begin
				aligned_load.value = {NUM_LANES{swapped_word}};
				aligned_load.mask = gather_oh & mem_result.lane_mask;
			end
			default: aligned_load.mask = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rollback_arbiter.sv ====
// Picks the single rollback or fault caused by the retiring result, combinationally
`default_nettype none
`timescale 1ns/1ps

module rollback_arbiter
	import isa_pkg::*;
	import core_config_pkg::*;
(
	input wire int_result_t int_result,
	input wire mem_result_t mem_result,
	input wire aligned_load_t aligned_load,
	input wire scalar_t fault_handler,
	input wire scalar_t tlb_miss_handler,
	output rollback_t rollback,
	output fault_t fault
);

	logic int_fault;
	logic mem_fault;
	logic int_pc_write;
	logic mem_pc_load;

	assign int_fault = int_result.valid && (int_result.instruction.illegal
		|| int_result.instruction.ifetch_fault || int_result.instruction.tlb_miss);
	assign mem_fault = mem_result.valid && (mem_result.access_fault || mem_result.tlb_miss);
	assign int_pc_write = int_result.valid && int_result.instruction.has_dest
		&& int_result.instruction.dest_reg == REG_PC
		&& !int_result.instruction.dest_is_vector;

	// A cache miss wins over the PC load, the data is not there yet
	assign mem_pc_load = mem_result.valid && mem_result.instruction.has_dest
		&& mem_result.instruction.dest_reg == REG_PC
		&& !mem_result.instruction.dest_is_vector && !mem_result.rollback_en;

	always_comb
	begin
		rollback = '0;
		fault = '0;

		if (int_fault)
		begin
			rollback.en = 1'b1;
			rollback.thread = int_result.thread;
			rollback.pipeline = PIPE_ARITH;
			if (int_result.instruction.tlb_miss)
				rollback.pc = tlb_miss_handler;
			else
				rollback.pc = fault_handler;

			fault.en = 1'b1;
			if (int_result.instruction.tlb_miss)
				fault.reason = FR_ITLB_MISS;
			else if (int_result.instruction.ifetch_fault)
				fault.reason = FR_IFETCH_FAULT;
			else
				fault.reason = FR_ILLEGAL_INSTRUCTION;

			fault.pc = int_result.instruction.pc;
			fault.thread = int_result.thread;
			fault.access_addr = int_result.instruction.pc;
		end
		else if (mem_fault)
		begin
			rollback.en = 1'b1;
			rollback.thread = mem_result.thread;
			rollback.pipeline = PIPE_MEM;
			fault.en = 1'b1;
			if (mem_result.tlb_miss)
			begin
				fault.reason = FR_DTLB_MISS;
				rollback.pc = tlb_miss_handler;
			end
			else
			begin
				fault.reason = FR_INVALID_ACCESS;
				rollback.pc = fault_handler;
			end

			fault.pc = mem_result.instruction.pc;
			fault.thread = mem_result.thread;
			fault.access_addr = scalar_t'(mem_result.offset);
		end
		else if (int_pc_write)
		begin
			rollback.en = 1'b1;
			rollback.thread = int_result.thread;
			rollback.pc = int_result.result[0];
			rollback.pipeline = PIPE_ARITH;
		end
		else if (mem_pc_load)
		begin
			rollback.en = 1'b1;
			rollback.thread = mem_result.thread;
			rollback.pc = aligned_load.swapped_word;
			rollback.pipeline = PIPE_MEM;
		end
		else if (int_result.valid && int_result.rollback_en)
		begin
			// Taken branch
			rollback.en = 1'b1;
			rollback.thread = int_result.thread;
			rollback.pc = int_result.rollback_pc;
			rollback.pipeline = PIPE_ARITH;
		end
		else if (mem_result.valid && mem_result.rollback_en)
		begin
			// Data cache miss, replay the instruction
			rollback.en = 1'b1;
			rollback.thread = mem_result.thread;
			rollback.pc = mem_result.rollback_pc;
			rollback.pipeline = PIPE_MEM;
		end
	end

endmodule

`default_nettype wire

// ==== writeback_register.sv ====
// One-deep register that holds the register file write of the result retired last cycle
`default_nettype none
`timescale 1ns/1ps

module writeback_register
	import isa_pkg::*;
	import core_config_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire int_result_t int_result,
	input wire mem_result_t mem_result,
	input wire aligned_load_t aligned_load,
	input wire rollback_t rollback,
	output writeback_t writeback
);

	logic int_rolled_back;
	logic mem_rolled_back;
	logic is_call;
	vector_t compare_value;

	// Only one result retires per cycle, the pipeline field tells whose rollback it is
	assign int_rolled_back = rollback.en && rollback.pipeline == PIPE_ARITH;
	assign mem_rolled_back = rollback.en && rollback.pipeline == PIPE_MEM;

	// Calls redirect fetch and still write the return address
	assign is_call = int_result.instruction.is_branch
		&& (int_result.instruction.branch_type == BRANCH_CALL_OFFSET
		|| int_result.instruction.branch_type == BRANCH_CALL_REGISTER);

	// One compare bit per lane, packed into the low bits of lane 0
	always_comb
	begin
		compare_value = '0;
		for (int i = 0; i < NUM_LANES; i++)
			compare_value[0][i] = int_result.result[i][0];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			writeback <= '0;
		else if (int_result.valid)
		begin
			writeback.en <= is_call || (int_result.instruction.has_dest && !int_rolled_back);
			writeback.thread <= int_result.thread;
			writeback.is_vector <= int_result.instruction.dest_is_vector;
			writeback.reg_idx <= int_result.instruction.dest_reg;
			writeback.mask <= int_result.mask;
			if (int_result.instruction.is_compare)
				writeback.value <= compare_value;
			else
				writeback.value <= int_result.result;
		end
		else if (mem_result.valid)
		begin
			writeback.en <= mem_result.instruction.has_dest && !mem_rolled_back;
			writeback.thread <= mem_result.thread;
			writeback.is_vector <= mem_result.instruction.dest_is_vector;
			writeback.reg_idx <= mem_result.instruction.dest_reg;

			// Stores and cache control ops leave value and mask alone
			if (mem_result.instruction.is_load && !mem_result.instruction.is_cache_control)
			begin
				writeback.value <= aligned_load.value;
				writeback.mask <= aligned_load.mask;
			end
		end
		else
			writeback.en <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== writeback_stage.sv ====
// Retire stage top level, connects the load aligner, rollback arbiter and writeback register
`default_nettype none
`timescale 1ns/1ps

module writeback_stage
	import core_config_pkg::*;
(
	input wire logic clk,
	input wire logic reset,

	// Retiring results, at most one valid per cycle
	input wire int_result_t int_result,
	input wire mem_result_t mem_result,
	input wire store_bypass_t bypass,

	// Handler addresses for faults
	input wire scalar_t fault_handler,
	input wire scalar_t tlb_miss_handler,

	// Same cycle redirect
	output rollback_t rollback,
	output fault_t fault,

	// Register file write, one cycle later
	output writeback_t writeback
);

	aligned_load_t aligned_load;

	load_aligner u_load_aligner (
		.mem_result(mem_result),
		.bypass(bypass),
		.aligned_load(aligned_load)
	);

	rollback_arbiter u_rollback_arbiter (
		.int_result(int_result),
		.mem_result(mem_result),
		.aligned_load(aligned_load),
		.fault_handler(fault_handler),
		.tlb_miss_handler(tlb_miss_handler),
		.rollback(rollback),
		.fault(fault)
	);

	writeback_register u_writeback_register (
		.clk(clk),
		.reset(reset),
		.int_result(int_result),
		.mem_result(mem_result),
		.aligned_load(aligned_load),
		.rollback(rollback),
		.writeback(writeback)
	);

endmodule

`default_nettype wire

// ==== writeback_stage_props.sv ====
// Port level assertions for the retire stage that bind attaches to every writeback_stage instance
`default_nettype none
`timescale 1ns/1ps

module writeback_stage_props
	import core_config_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire int_result_t int_result,
	input wire mem_result_t mem_result,
	input wire rollback_t rollback,
	input wire fault_t fault,
	input wire writeback_t writeback
);

	// Number of failed assertions, watched by the testbench
	int failure_count = 0;

	// Only one pipe retires per cycle
	one_result: assert property (@(posedge clk) disable iff (reset)
		!(int_result.valid && mem_result.valid))
	else
	begin
		failure_count++;
		$error("Integer and memory results are valid in the same cycle");
	end

	wb_idle_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> !writeback.en)
	else
	begin
		failure_count++;
		$error("Register file write enabled during reset");
	end

	fault_rolls_back: assert property (@(posedge clk) disable iff (reset)
		fault.en |-> rollback.en)
	else
	begin
		failure_count++;
		$error("Fault raised without a rollback");
	end

	// Nothing retiring means nothing to redirect
	idle_no_rollback: assert property (@(posedge clk) disable iff (reset)
		!int_result.valid && !mem_result.valid |-> !rollback.en)
	else
	begin
		failure_count++;
		$error("Rollback raised with no valid result");
	end

endmodule

bind writeback_stage writeback_stage_props u_writeback_stage_props (
	.clk(clk),
	.reset(reset),
	.int_result(int_result),
	.mem_result(mem_result),
	.rollback(rollback),
	.fault(fault),
	.writeback(writeback)
);

`default_nettype wire

// ==== writeback_stage_tb.sv ====
// Testbench for the retire stage that drives LFSR stimulus per behavior and checks a reference model
`default_nettype none
`timescale 1ns/1ps

module writeback_stage_tb
	import isa_pkg::*;
	import core_config_pkg::*;
();

	localparam int N_INT = 48;
	localparam int N_SCALAR = 48;
	localparam int N_VECTOR = 32;
	localparam int N_FAULT = 20;
	localparam int N_REDIRECT = 24;
	localparam int N_MISS = 8;
	localparam int RESET_CYCLES = 3;
	// One idle cycle after each of the six tests and three more to drain
	localparam int TOTAL_CYCLES = RESET_CYCLES + N_INT + N_SCALAR + N_VECTOR + N_FAULT
		+ N_REDIRECT + N_MISS + 6 + 3;
	localparam int CYCLE_LIMIT = 2 * TOTAL_CYCLES + 20;

	typedef struct packed
	{
		rollback_t rollback;
		fault_t fault;
		writeback_t writeback;
	} expected_t;

	logic clk;
	logic reset;
	int_result_t int_result;
	mem_result_t mem_result;
	store_bypass_t bypass;
	scalar_t fault_handler;
	scalar_t tlb_miss_handler;
	rollback_t rollback;
	fault_t fault;
	writeback_t writeback;

	logic [31:0] lfsr_state = 32'h5273;
	writeback_t model_wb;
	writeback_t expected_wb_q[$];
	string expected_name_q[$];
	string test_name = "reset";
	int cycle_count = 0;
	int error_count = 0;

	writeback_stage u_writeback_stage (
		.clk(clk),
		.reset(reset),
		.int_result(int_result),
		.mem_result(mem_result),
		.bypass(bypass),
		.fault_handler(fault_handler),
		.tlb_miss_handler(tlb_miss_handler),
		.rollback(rollback),
		.fault(fault),
		.writeback(writeback)
	);

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
	function automatic logic [255:0] random_bits(input int count);
		logic [255:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			bits = {bits[254:0], lfsr_state[0]};
		end
		return bits;
	endfunction

	function automatic int random_below(input int limit);
		return int'(random_bits(16) % limit);
	endfunction

	// Byte at a big endian line offset after the store queue bypass
	function automatic logic [7:0] line_byte(input mem_result_t mr, input store_bypass_t bp,
		input int offset);
		int pos;
		pos = LINE_BYTES - 1 - offset;
		return bp.mask[pos] ? bp.data[pos * 8 +: 8] : mr.load_data[pos * 8 +: 8];
	endfunction

	function automatic expected_t reference_model(input int_result_t ir, input mem_result_t mr,
		input store_bypass_t bp, input scalar_t fh, input scalar_t th, input writeback_t prev);
		expected_t e;
		decoded_instruction_t ii;
		decoded_instruction_t mi;
		fault_reason_t reason;
		int base;
		int half;
		logic [7:0] b;
		logic [15:0] h;
		scalar_t swapped;
		vector_t value;
		lane_mask_t mask;
		logic is_call;

		ii = ir.instruction;
		mi = mr.instruction;
		base = mr.offset & 4'hc;
		half = base + (mr.offset[1] ? 2 : 0);
		b = line_byte(mr, bp, mr.offset);
		h = {line_byte(mr, bp, half + 1), line_byte(mr, bp, half)};
		swapped = {line_byte(mr, bp, base + 3), line_byte(mr, bp, base + 2),
			line_byte(mr, bp, base + 1), line_byte(mr, bp, base)};
		value = '0;
		mask = '1;
		case (mi.memory_access_type)
			MEM_B: value[0] = {24'b0, b};
			MEM_BX: value[0] = {{24{b[7]}}, b};
			MEM_S: value[0] = {16'b0, h};
			MEM_SX: value[0] = {{16{h[15]}}, h};
			MEM_L: value[0] = swapped;
			MEM_BLOCK:
			begin
				for (int l = 0; l < NUM_LANES; l++)
					value[l] = {line_byte(mr, bp, 4 * l + 3), line_byte(mr, bp, 4 * l + 2),
						line_byte(mr, bp, 4 * l + 1), line_byte(mr, bp, 4 * l)};
				mask = mr.lane_mask;
			end
			MEM_GATHER:
			begin
				for (int l = 0; l < NUM_LANES; l++)
					value[l] = swapped;
				mask = lane_mask_t'(4'b1000 >> mr.gather_lane) & mr.lane_mask;
			end
		endcase

		e = '0;
		if (ir.valid && (ii.illegal || ii.ifetch_fault || ii.tlb_miss))
		begin
			if (ii.tlb_miss)
				reason = FR_ITLB_MISS;
			else if (ii.ifetch_fault)
				reason = FR_IFETCH_FAULT;
			else
				reason = FR_ILLEGAL_INSTRUCTION;
			e.rollback = '{1'b1, ir.thread, ii.tlb_miss ? th : fh, PIPE_ARITH};
			e.fault = '{1'b1, reason, ii.pc, ir.thread, ii.pc};
		end
		else if (mr.valid && (mr.access_fault || mr.tlb_miss))
		begin
			reason = mr.tlb_miss ? FR_DTLB_MISS : FR_INVALID_ACCESS;
			e.rollback = '{1'b1, mr.thread, mr.tlb_miss ? th : fh, PIPE_MEM};
			e.fault = '{1'b1, reason, mi.pc, mr.thread, scalar_t'(mr.offset)};
		end
		else if (ir.valid && ii.has_dest && ii.dest_reg == REG_PC && !ii.dest_is_vector)
			e.rollback = '{1'b1, ir.thread, ir.result[0], PIPE_ARITH};
		else if (mr.valid && mi.has_dest && mi.dest_reg == REG_PC && !mi.dest_is_vector
			&& !mr.rollback_en)
			e.rollback = '{1'b1, mr.thread, swapped, PIPE_MEM};
		else if (ir.valid && ir.rollback_en)
			e.rollback = '{1'b1, ir.thread, ir.rollback_pc, PIPE_ARITH};
		else if (mr.valid && mr.rollback_en)
			e.rollback = '{1'b1, mr.thread, mr.rollback_pc, PIPE_MEM};

		// Register file fields hold their value when nothing retires
		e.writeback = prev;
		e.writeback.en = 1'b0;
		if (ir.valid)
		begin
			is_call = ii.is_branch
				&& (ii.branch_type inside {BRANCH_CALL_OFFSET, BRANCH_CALL_REGISTER});
			e.writeback.en = is_call || (ii.has_dest && !e.rollback.en);
			e.writeback.thread = ir.thread;
			e.writeback.is_vector = ii.dest_is_vector;
			e.writeback.reg_idx = ii.dest_reg;
			e.writeback.mask = ir.mask;
			e.writeback.value = ir.result;
			if (ii.is_compare)
			begin
				e.writeback.value = '0;
				for (int l = 0; l < NUM_LANES; l++)
					e.writeback.value[0][l] = ir.result[l][0];
			end
		end
		else if (mr.valid)
		begin
			e.writeback.en = mi.has_dest && !e.rollback.en;
			e.writeback.thread = mr.thread;
			e.writeback.is_vector = mi.dest_is_vector;
			e.writeback.reg_idx = mi.dest_reg;
			if (mi.is_load && !mi.is_cache_control)
			begin
				e.writeback.value = value;
				e.writeback.mask = mask;
			end
		end
		return e;
	endfunction

	task automatic check_value(input string name, input string field,
		input logic [159:0] expected, input logic [159:0] actual);
		if (expected !== actual)
		begin
			error_count++;
			$display("[FAIL] %s %s expected %h actual %h", name, field, expected, actual);
			$display("*** TEST FAILED ***");
			$fatal(1, "Mismatch on %s in %s", field, name);
		end
	endtask

	// Kind 0 is integer, 1 scalar load, 2 block or gather, 3 fault, 4 redirect, 5 miss, 6 idle
	task automatic make_stimulus(input int kind, input int index, output int_result_t ir,
		output mem_result_t mr, output store_bypass_t bp);
		logic [255:0] r;
		decoded_instruction_t inst;

		r = random_bits($bits(int_result_t));
		ir = r[$bits(int_result_t) - 1:0];
		r = random_bits($bits(mem_result_t));
		mr = r[$bits(mem_result_t) - 1:0];
		r = random_bits($bits(store_bypass_t));
		bp = r[$bits(store_bypass_t) - 1:0];
		r = random_bits($bits(decoded_instruction_t));
		inst = r[$bits(decoded_instruction_t) - 1:0];
		inst.illegal = 1'b0;
		inst.ifetch_fault = 1'b0;
		inst.tlb_miss = 1'b0;
		inst.branch_type = branch_type_t'(random_below(3));
		inst.memory_access_type = memory_op_t'(random_below(7));
		ir.valid = 1'b0;
		ir.rollback_en = 1'b0;
		mr.valid = 1'b0;
		mr.rollback_en = 1'b0;
		mr.access_fault = 1'b0;
		mr.tlb_miss = 1'b0;
		case (kind)
			0:
			begin
				ir.valid = random_below(8) != 0;
				ir.rollback_en = random_below(4) == 0;
			end
			1, 2:
			begin
				mr.valid = 1'b1;
				inst.has_dest = 1'b1;
				inst.is_cache_control = 1'b0;
				inst.is_load = kind == 1 || random_below(4) != 0;
				inst.dest_is_vector = kind == 2;
				if (inst.dest_reg == REG_PC)
					inst.dest_reg = 5'd0;
				if (kind == 1)
					inst.memory_access_type = memory_op_t'(random_below(5));
				else
					inst.memory_access_type = random_below(2) ? MEM_GATHER : MEM_BLOCK;
			end
			3:
			begin
				inst.is_branch = 1'b0;
				ir.valid = index % 5 < 3;
				mr.valid = index % 5 >= 3;
				inst.illegal = index % 5 == 0 || (index % 5 > 0 && random_below(2));
				inst.ifetch_fault = index % 5 == 1 || (index % 5 == 2 && random_below(2));
				inst.tlb_miss = index % 5 == 2;
				mr.tlb_miss = index % 5 == 3;
				mr.access_fault = index % 5 == 4 || (index % 5 == 3 && random_below(2));
				mr.rollback_en = random_below(2);
			end
			4:
			begin
				ir.valid = index % 4 != 1;
				mr.valid = index % 4 == 1;
				inst.has_dest = 1'b1;
				inst.dest_is_vector = 1'b0;
				inst.dest_reg = index % 4 < 2 ? REG_PC : 5'd30;
				inst.is_branch = index % 4 >= 2;
				inst.is_load = 1'b1;
				inst.is_cache_control = 1'b0;
				inst.memory_access_type = MEM_L;
				ir.rollback_en = index % 4 >= 2;
				if (index % 4 == 2)
					inst.branch_type = BRANCH_OTHER;
				else if (index % 4 == 3)
					inst.branch_type = branch_type_t'(random_below(2));
			end
			5:
			begin
				mr.valid = 1'b1;
				mr.rollback_en = 1'b1;
				inst.has_dest = 1'b1;
				inst.dest_is_vector = 1'b0;
				inst.dest_reg = REG_PC;
				inst.is_load = 1'b1;
			end
			default:
			begin
			end
		endcase
		ir.instruction = inst;
		mr.instruction = inst;
	endtask

	task automatic run_test(input string name, input int kind, input int count);
		int_result_t ir;
		mem_result_t mr;
		store_bypass_t bp;
		for (int i = 0; i <= count; i++)
		begin
			// The extra last cycle is idle
			make_stimulus(i < count ? kind : 6, i, ir, mr, bp);
			@(negedge clk);
			test_name = name;
			int_result = ir;
			mem_result = mr;
			bypass = bp;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Rollback and fault are checked in the input cycle and writeback at the next falling edge
	always @(posedge clk)
	begin : compare
		expected_t expected;
		if (!reset)
		begin
			expected = reference_model(int_result, mem_result, bypass, fault_handler,
				tlb_miss_handler, model_wb);
			model_wb = expected.writeback;
			check_value(test_name, "rollback", 160'(expected.rollback), 160'(rollback));
			check_value(test_name, "fault", 160'(expected.fault), 160'(fault));
			expected_wb_q.push_back(expected.writeback);
			expected_name_q.push_back(test_name);
			@(negedge clk);
			check_value(expected_name_q.pop_front(), "writeback",
				160'(expected_wb_q.pop_front()), 160'(writeback));
		end
	end

	// Bound assertions fire after the rising edge, so look at the falling edge
	always @(negedge clk)
	begin
		if (u_writeback_stage.u_writeback_stage_props.failure_count != 0)
		begin
			$display("A bound assertion on the retire stage ports failed during %s", test_name);
			$display("*** TEST FAILED ***");
			$fatal(1, "Assertion failure");
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	initial
	begin
		reset = 1'b1;
		int_result = '0;
		mem_result = '0;
		bypass = '0;
		fault_handler = 32'h0000_8000;
		tlb_miss_handler = 32'h0000_9000;
		model_wb = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		run_test("integer_retire", 0, N_INT);
		run_test("scalar_loads", 1, N_SCALAR);
		run_test("block_gather_loads", 2, N_VECTOR);
		run_test("faults", 3, N_FAULT);
		run_test("pc_redirects", 4, N_REDIRECT);
		run_test("memory_rollback", 5, N_MISS);
		repeat (3) @(negedge clk);
		if (error_count == 0 && u_writeback_stage.u_writeback_stage_props.failure_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== writeback_stage.f ====
isa_pkg.sv
core_config_pkg.sv
load_aligner.sv
rollback_arbiter.sv
writeback_register.sv
writeback_stage.sv
writeback_stage_props.sv
writeback_stage_tb.sv
